// ==== hdl/aes_sts_pkg.sv ====
`default_nettype none

package aes_sts_pkg;

   // Data beat and status word
   typedef logic [31:0] data_t;

   // Byte enables of one data beat
   typedef logic [3:0] keep_t;

   // Frame byte count
   // Same width in the EOF record and in status word 0
   typedef logic [15:0] byte_cnt_t;

   // Status record builder states
   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_DATA,
      ST_EOF,
      ST_DONE
   } sts_state_t;

   // Flag nibble of status word 0
   // Byte count goes into bits 15:0
   localparam data_t STS_FLAG_WORD = 32'h5000_0000;

   // Zero words after word 0
   // Last one carries tlast
   localparam logic [2:0] STS_TAIL_WORDS = 3'd4;

   // EOF FIFO of 4 records
   localparam int EOF_FIFO_DEPTH_LOG2 = 2;

   // Status FIFO of 16 words
   localparam int STS_FIFO_DEPTH_LOG2 = 4;

   // Status FIFO level that blocks a new record
   // 16 - 11 leaves room for one full record of five words
   localparam logic [STS_FIFO_DEPTH_LOG2:0] STS_PROG_FULL = 5'd11;

endpackage

`default_nettype wire

// ==== hdl/aes_sts_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// EOF records from the tracker, through the EOF FIFO, to the status FSM
interface eof_if;

   // Write side, one strobe per frame
   logic                   wr_en;
   aes_sts_pkg::byte_cnt_t wr_data;
   logic                   full;

   // Read side, first word falls through
   logic                   rd_en;
   aes_sts_pkg::byte_cnt_t rd_data;
   logic                   empty;

   modport tracker (output wr_en, output wr_data, input full);

   modport fsm (output rd_en, input rd_data, input empty);

   modport fifo (
      input  wr_en,
      input  wr_data,
      output full,
      input  rd_en,
      output rd_data,
      output empty
   );

endinterface

// Status words from the FSM into the status FIFO
interface sts_wr_if;

   logic               wr_en;
   logic               wr_last;
   aes_sts_pkg::data_t wr_data;
   // Not enough room for another record
   logic               prog_full;

   modport fsm (output wr_en, output wr_last, output wr_data, input prog_full);

   modport fifo (input wr_en, input wr_last, input wr_data, output prog_full);

endinterface

`default_nettype wire

// ==== hdl/aes_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_sync_fifo #(
   parameter int width      = 32,
   parameter int depth_log2 = 4
) (
   input  wire                  m_axi_mm2s_aclk,
   input  wire                  rst_n,
   input  wire                  wr_en,
   input  wire  [width-1:0]     wr_data,
   input  wire                  rd_en,
   input  wire  [depth_log2:0]  prog_level,
   output logic [width-1:0]     rd_data,
   output logic                 empty,
   output logic                 full,
   output logic                 prog_full
);

   // Entry storage
   logic [width-1:0]      mem [2**depth_log2];
   logic [depth_log2-1:0] wr_ptr;
   logic [depth_log2-1:0] rd_ptr;
   // One bit wider than the pointers to tell full from empty
   logic [depth_log2:0]   count;
   logic [depth_log2:0]   count_next;

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
   end

   // Head entry always on the output
   assign rd_data = mem[rd_ptr];

   // Level after this cycle's strobes
   always_comb
   begin
      count_next = count;
      if (wr_en && !rd_en)
         count_next = count + 1'b1;
      else if (rd_en && !wr_en)
         count_next = count - 1'b1;
   end

   // Pointers wrap on their own width
   // Flags come out of registers, valid right after the edge
   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         empty     <= 1'b1;
         full      <= 1'b0;
         prog_full <= 1'b0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         count     <= count_next;
         empty     <= (count_next == '0);
         // MSB only set at exactly 2**depth_log2 entries
         full      <= count_next[depth_log2];
         prog_full <= (count_next >= prog_level);
      end
   end

   // Writers and readers sit in other modules and must honor the flags
   a_no_wr_full: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n)
      wr_en |-> !full)
      else $error("aes_sync_fifo: write while full");

   a_no_rd_empty: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n)
      rd_en |-> !empty)
      else $error("aes_sync_fifo: read while empty");

endmodule

`default_nettype wire

// ==== hdl/aes_frame_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_frame_tracker (
   input  wire                     m_axi_mm2s_aclk,
   input  wire                     rst_n,
   input  wire aes_sts_pkg::data_t mm2s_tdata,
   input  wire aes_sts_pkg::keep_t mm2s_tkeep,
   input  wire                     mm2s_tvalid,
   input  wire                     mm2s_tlast,
   output logic                    mm2s_tready,
   eof_if.tracker                  eof
);

   aes_sts_pkg::byte_cnt_t byte_cnt;
   aes_sts_pkg::byte_cnt_t beat_bytes;
   aes_sts_pkg::byte_cnt_t frame_bytes;
   aes_sts_pkg::byte_cnt_t wr_data_q;
   logic                   wr_en_q;
   logic                   beat_ok;

   // Stall one cycle while a record write is in flight
   // Full flag only catches up one edge after that write
   assign mm2s_tready = !(eof.full || wr_en_q);
   assign beat_ok     = mm2s_tvalid && mm2s_tready;

   // Bytes in this beat
   assign beat_bytes  = aes_sts_pkg::byte_cnt_t'($countones(mm2s_tkeep));
   // Running total including this beat
   assign frame_bytes = byte_cnt + beat_bytes;

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n)
      begin
         byte_cnt <= '0;
         wr_en_q  <= 1'b0;
      end
      else
      begin
         // One record per frame, one cycle after the last beat
         wr_en_q <= beat_ok && mm2s_tlast;
         if (beat_ok)
            byte_cnt <= mm2s_tlast ? '0 : frame_bytes;
      end
   end

   // Completed count held for the write strobe
   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (beat_ok && mm2s_tlast)
         wr_data_q <= frame_bytes;
   end

   assign eof.wr_en   = wr_en_q;
   assign eof.wr_data = wr_data_q;

   // Only the last beat of a frame may be partial
   a_keep_full: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n)
      (beat_ok && !mm2s_tlast) |-> (&mm2s_tkeep))
      else $error("aes_frame_tracker: partial keep on a non-last beat");

   // Payload is dropped here but must still be driven by the engine
   a_data_known: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n)
      beat_ok |-> !$isunknown(mm2s_tdata))
      else $error("aes_frame_tracker: unknown data on an accepted beat");

endmodule

`default_nettype wire

// ==== hdl/aes_sts_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_sts_fsm (
   input wire m_axi_mm2s_aclk,
   input wire rst_n,
   eof_if.fsm    eof,
   sts_wr_if.fsm sts
);

   aes_sts_pkg::sts_state_t state;
   aes_sts_pkg::sts_state_t state_next;

   // Zero words still to go in the eof state
   logic [$bits(aes_sts_pkg::STS_TAIL_WORDS)-1:0] tail_cnt;
   logic                                          tail_end;

   // Registered write side of the status FIFO
   logic               wr_en_q;
   logic               wr_last_q;
   aes_sts_pkg::data_t wr_data_q;

   // Fourth zero word this cycle
   assign tail_end = (tail_cnt == 1'b1);

   always_comb
   begin
      state_next = state;
      case (state)
         aes_sts_pkg::ST_IDLE:
            // Need a record and room for all five words
            if (!eof.empty && !sts.prog_full)
               state_next = aes_sts_pkg::ST_DATA;
         aes_sts_pkg::ST_DATA:
            state_next = aes_sts_pkg::ST_EOF;
         aes_sts_pkg::ST_EOF:
            if (tail_end)
               state_next = aes_sts_pkg::ST_DONE;
         aes_sts_pkg::ST_DONE:
            // EOF pop lands on this edge
            state_next = aes_sts_pkg::ST_IDLE;
         default:
            state_next = aes_sts_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (!rst_n)
      begin
         state     <= aes_sts_pkg::ST_IDLE;
         tail_cnt  <= '0;
         wr_en_q   <= 1'b0;
         wr_last_q <= 1'b0;
      end
      else
      begin
         state <= state_next;
         // Word 0 after data, zero words after each eof cycle
         wr_en_q   <= (state == aes_sts_pkg::ST_DATA) || (state == aes_sts_pkg::ST_EOF);
         wr_last_q <= (state == aes_sts_pkg::ST_EOF) && tail_end;
         // Count down 4..1 across the eof state
         if (state == aes_sts_pkg::ST_DATA)
            tail_cnt <= aes_sts_pkg::STS_TAIL_WORDS;
         else if (state == aes_sts_pkg::ST_EOF)
            tail_cnt <= tail_cnt - 1'b1;
      end
   end

   // Head record stays on the FIFO output until the pop
   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (state == aes_sts_pkg::ST_DATA)
         wr_data_q <= aes_sts_pkg::STS_FLAG_WORD | aes_sts_pkg::data_t'(eof.rd_data);
      else
         wr_data_q <= '0;
   end

   assign sts.wr_en   = wr_en_q;
   assign sts.wr_last = wr_last_q;
   assign sts.wr_data = wr_data_q;

   // Pop the EOF record together with the last status word
   assign eof.rd_en = wr_last_q;

   a_last_with_en: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n)
      sts.wr_last |-> sts.wr_en)
      else $error("aes_sts_fsm: wr_last without wr_en");

   // Known state, and the head record stays in the EOF FIFO until its pop
   a_state_legal: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n)
      !$isunknown(state) && ((state == aes_sts_pkg::ST_IDLE) || !eof.empty))
      else $error("aes_sts_fsm: illegal state");

endmodule

`default_nettype wire

// ==== hdl/aes_sts_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_sts_top (
   input  wire                      m_axi_mm2s_aclk,
   input  wire                      rst_n,
   input  wire aes_sts_pkg::data_t  mm2s_tdata,
   input  wire aes_sts_pkg::keep_t  mm2s_tkeep,
   input  wire                      mm2s_tvalid,
   input  wire                      mm2s_tlast,
   output logic                     mm2s_tready,
   output aes_sts_pkg::data_t       sts_tdata,
   output logic                     sts_tvalid,
   output logic                     sts_tlast,
   input  wire                      sts_tready
);

   eof_if    eof_bus ();
   sts_wr_if sts_bus ();

   // Status FIFO entry is tlast on top of the data word
   logic [$bits(aes_sts_pkg::data_t):0] sts_wr_entry;
   logic [$bits(aes_sts_pkg::data_t):0] sts_rd_entry;
   logic                                sts_empty;
   logic                                sts_rd_en;

   // Beat counting, one EOF record per frame
   aes_frame_tracker u_tracker (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n           (rst_n),
      .mm2s_tdata      (mm2s_tdata),
      .mm2s_tkeep      (mm2s_tkeep),
      .mm2s_tvalid     (mm2s_tvalid),
      .mm2s_tlast      (mm2s_tlast),
      .mm2s_tready     (mm2s_tready),
      .eof             (eof_bus.tracker)
   );

   // Only full matters here, so prog_level sits at the depth
   aes_sync_fifo #(
      .width      ($bits(aes_sts_pkg::byte_cnt_t)),
      .depth_log2 (aes_sts_pkg::EOF_FIFO_DEPTH_LOG2)
   ) eof_fifo (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n           (rst_n),
      .wr_en           (eof_bus.wr_en),
      .wr_data         (eof_bus.wr_data),
      .rd_en           (eof_bus.rd_en),
      .prog_level      ({1'b1, {aes_sts_pkg::EOF_FIFO_DEPTH_LOG2{1'b0}}}),
      .rd_data         (eof_bus.rd_data),
      .empty           (eof_bus.empty),
      .full            (eof_bus.full),
      .prog_full       ()
   );

   aes_sts_fsm u_fsm (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n           (rst_n),
      .eof             (eof_bus.fsm),
      .sts             (sts_bus.fsm)
   );

   assign sts_wr_entry = {sts_bus.wr_last, sts_bus.wr_data};

   // Prog-full gates the FSM, so the hard full flag goes unused
   aes_sync_fifo #(
      .width      ($bits(aes_sts_pkg::data_t) + 1),
      .depth_log2 (aes_sts_pkg::STS_FIFO_DEPTH_LOG2)
   ) sts_fifo (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n           (rst_n),
      .wr_en           (sts_bus.wr_en),
      .wr_data         (sts_wr_entry),
      .rd_en           (sts_rd_en),
      .prog_level      (aes_sts_pkg::STS_PROG_FULL),
      .rd_data         (sts_rd_entry),
      .empty           (sts_empty),
      .full            (),
      .prog_full       (sts_bus.prog_full)
   );

   // Output stream straight off the FIFO head
   assign sts_tvalid = !sts_empty;
   assign sts_rd_en  = sts_tvalid && sts_tready;
   assign sts_tlast  = sts_rd_entry[$bits(aes_sts_pkg::data_t)];
   assign sts_tdata  = sts_rd_entry[$bits(aes_sts_pkg::data_t)-1:0];

endmodule

`default_nettype wire

// ==== sim/tb_aes_sts_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aes_sts_top;

   localparam int N_FRAMES = 8;
   localparam int TIMEOUT  = 400;

   logic                   m_axi_mm2s_aclk;
   logic                   rst_n;
   aes_sts_pkg::data_t     mm2s_tdata;
   aes_sts_pkg::keep_t     mm2s_tkeep;
   logic                   mm2s_tvalid;
   logic                   mm2s_tlast;
   logic                   mm2s_tready;
   aes_sts_pkg::data_t     sts_tdata;
   logic                   sts_tvalid;
   logic                   sts_tlast;
   logic                   sts_tready;

   // Frame table, one column per array
   // Beats, last keep, ready stall mask (1 = stall), expected byte count
   int                     tab_beats [N_FRAMES] = '{1, 1, 1, 1, 3, 4, 2, 6};
   aes_sts_pkg::keep_t     tab_keep  [N_FRAMES] = '{4'hf, 4'h1, 4'h3, 4'h7,
                                                    4'hf, 4'h1, 4'h3, 4'h7};
   logic [7:0]             tab_stall [N_FRAMES] = '{8'h00, 8'h00, 8'h55, 8'h0f,
                                                    8'h81, 8'h33, 8'hf0, 8'h24};
   aes_sts_pkg::byte_cnt_t tab_count [N_FRAMES] = '{16'd4, 16'd1, 16'd2, 16'd3,
                                                    16'd12, 16'd13, 16'd6, 16'd23};

   integer seed = 32'h8704_5f16;
   // Table rows of the batch in flight, in send order
   int     batch_q[$];
   int     word_total;

   aes_sts_top uut (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n           (rst_n),
      .mm2s_tdata      (mm2s_tdata),
      .mm2s_tkeep      (mm2s_tkeep),
      .mm2s_tvalid     (mm2s_tvalid),
      .mm2s_tlast      (mm2s_tlast),
      .mm2s_tready     (mm2s_tready),
      .sts_tdata       (sts_tdata),
      .sts_tvalid      (sts_tvalid),
      .sts_tlast       (sts_tlast),
      .sts_tready      (sts_tready)
   );

   always #10 m_axi_mm2s_aclk = ~m_axi_mm2s_aclk;

   // Every status word handed over on the output stream
   always @(posedge m_axi_mm2s_aclk)
   begin
      if (rst_n && sts_tvalid && sts_tready)
         word_total++;
   end

   task automatic abort_test(input string msg);
   begin
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   end
   endtask

   task automatic compare_word(input string name, input aes_sts_pkg::data_t exp,
                               input aes_sts_pkg::data_t act);
   begin
      if (act !== exp)
         abort_test($sformatf("FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                              $time, name, exp, act));
   end
   endtask

   task automatic compare_last(input string name, input bit exp, input logic act);
   begin
      if (act !== exp)
         abort_test($sformatf("FAILED at %0t: %s expected %0b, got %0b", $time, name, exp, act));
   end
   endtask

   task automatic compare_count(input string name, input aes_sts_pkg::byte_cnt_t exp,
                                input aes_sts_pkg::byte_cnt_t act);
   begin
      if (act !== exp)
         abort_test($sformatf("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act));
   end
   endtask

   task automatic compare_total(input string name, input int exp, input int act);
   begin
      if (act != exp)
         abort_test($sformatf("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act));
   end
   endtask

   // Starts and ends on a falling edge
   task automatic send_frame(input int idx);
      int b;
      int wait_cnt;
   begin
      for (b = 0; b < tab_beats[idx]; b++)
      begin
         // Tagged payload, only counted by the DUT
         mm2s_tdata  = 32'ha000_0000 | (idx << 8) | b;
         mm2s_tlast  = (b == tab_beats[idx] - 1);
         mm2s_tkeep  = mm2s_tlast ? tab_keep[idx] : 4'hf;
         mm2s_tvalid = 1'b1;
         wait_cnt    = 0;
         // Ready is registered, stable until the next rising edge
         while (!mm2s_tready)
         begin
            @(negedge m_axi_mm2s_aclk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT)
               abort_test($sformatf("Timeout: mm2s_tready stayed low, frame %0d beat %0d", idx, b));
         end
         @(negedge m_axi_mm2s_aclk);
      end
   end
   endtask

   // Mode 0 table stall mask, 1 hold until input blocks, 2 random stalls
   task automatic collect_words(input int mode);
      int rec;
      int w;
      int cyc;
      int idle;
      int low_run;
      bit released;
      aes_sts_pkg::byte_cnt_t cnt;
   begin
      rec      = 0;
      w        = 0;
      cyc      = 0;
      idle     = 0;
      low_run  = 0;
      released = (mode != 1);
      while (rec < batch_q.size())
      begin
         @(negedge m_axi_mm2s_aclk);
         if (mode == 0)
            sts_tready = !tab_stall[batch_q[rec]][cyc % 8];
         else if (mode == 1)
         begin
            // A single low cycle is just the record write, a long one means full FIFOs
            low_run = mm2s_tready ? 0 : low_run + 1;
            if (low_run >= 3)
               released = 1'b1;
            sts_tready = released;
         end
         else
            sts_tready = (($random(seed) & 3) != 0);
         cyc++;
         if (sts_tvalid && sts_tready)
         begin
            cnt = tab_count[batch_q[rec]];
            if (w == 0)
            begin
               compare_count("byte count", cnt, sts_tdata[15:0]);
               compare_word("sts_tdata", {4'h5, 12'h000, cnt}, sts_tdata);
            end
            else
               compare_word("sts_tdata", 32'h0, sts_tdata);
            compare_last("sts_tlast", (w == 4), sts_tlast);
            idle = 0;
            w    = (w == 4) ? 0 : w + 1;
            if (w == 0)
               rec++;
         end
         else
         begin
            idle++;
            if (idle > TIMEOUT && !released)
               abort_test("Timeout: mm2s_tready never dropped while sts_tready was held low");
            else if (idle > TIMEOUT)
               abort_test($sformatf("Timeout: no status word, frame %0d word %0d", rec, w));
         end
      end
   end
   endtask

   // Nothing left over and the input side open again
   task automatic check_idle();
   begin
      sts_tready = 1'b1;
      repeat (16)
      begin
         @(negedge m_axi_mm2s_aclk);
         compare_last("sts_tvalid", 1'b0, sts_tvalid);
      end
      compare_last("mm2s_tready", 1'b1, mm2s_tready);
   end
   endtask

   task automatic run_batch(input int first, input int n, input int mode);
      int k;
   begin
      batch_q.delete();
      for (k = 0; k < n; k++)
         batch_q.push_back(first + k);
      fork
         begin
            for (int j = 0; j < n; j++)
               send_frame(batch_q[j]);
            mm2s_tvalid = 1'b0;
            mm2s_tlast  = 1'b0;
         end
         collect_words(mode);
      join
      check_idle();
   end
   endtask

   initial
   begin
      m_axi_mm2s_aclk = 1'b0;
      rst_n           = 1'b0;
      mm2s_tdata      = '0;
      mm2s_tkeep      = '0;
      mm2s_tvalid     = 1'b0;
      mm2s_tlast      = 1'b0;
      sts_tready      = 1'b0;
      word_total      = 0;
      repeat (8) @(negedge m_axi_mm2s_aclk);
      rst_n = 1'b1;
      @(negedge m_axi_mm2s_aclk);
      compare_last("sts_tvalid", 1'b0, sts_tvalid);
      compare_last("mm2s_tready", 1'b1, mm2s_tready);
      // One frame at a time with the table's stall mask
      for (int i = 0; i < N_FRAMES; i++)
         run_batch(i, 1, 0);
      // Whole table queued behind a stalled output
      run_batch(0, N_FRAMES, 1);
      // Whole table back to back under random stalls
      word_total = 0;
      run_batch(0, N_FRAMES, 2);
      compare_total("status word total", 5 * N_FRAMES, word_total);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== aes_sts_top.f ====
hdl/aes_sts_pkg.sv
hdl/aes_sts_if.sv
hdl/aes_sync_fifo.sv
hdl/aes_frame_tracker.sv
hdl/aes_sts_fsm.sv
hdl/aes_sts_top.sv
sim/tb_aes_sts_top.sv
